// ==== common/bp_pkg.sv ====
package bp_pkg;

    // table geometry
    localparam int HIST_BITS   = 5;
    localparam int PHT_ENTRIES = 32;
    localparam int BTB_ENTRIES = 32;

    typedef logic [31:0]                    addr_t;      // instruction address
    typedef logic [HIST_BITS-1:0]           hist_t;      // global branch history
    typedef logic [$clog2(PHT_ENTRIES)-1:0] pht_index_t; // pattern table index
    typedef logic [$clog2(BTB_ENTRIES)-1:0] btb_index_t; // pc[6:2]
    typedef logic [24:0]                    btb_tag_t;   // pc[31:7]
    typedef logic [1:0]                     counter_t;   // 2-bit saturating counter
    typedef logic [15:0]                    count_t;     // status counter
    typedef logic [1:0]                     cfg_addr_t;
    typedef logic [15:0]                    cfg_data_t;

    localparam counter_t COUNTER_INIT = 2'd1; // weakly not taken

    // config register map
    localparam cfg_addr_t REG_CONTROL     = 2'd0;
    localparam cfg_addr_t REG_BRANCHES    = 2'd1;
    localparam cfg_addr_t REG_MISPREDICTS = 2'd2;

    // one instruction resolved in execute
    // valid when is_branch or is_jump is set
    typedef struct packed {
        logic       is_branch;  // conditional branch
        logic       is_jump;    // jal or jalr
        logic       taken;      // actual direction
        logic       mispredict; // prediction was wrong
        addr_t      pc;
        addr_t      target;     // actual target
        pht_index_t pht_index;  // index handed out at lookup
    } resolve_t;

    // word-aligned pc split into buffer index and tag
    function automatic btb_index_t btb_index_of(input addr_t pc);
        btb_index_of = pc[6:2];
    endfunction

    function automatic btb_tag_t btb_tag_of(input addr_t pc);
        btb_tag_of = pc[31:7];
    endfunction

    // one step of the saturating counter toward the resolved direction
    function automatic counter_t counter_step(input counter_t cur, input logic taken);
        counter_t nxt;
        nxt = cur;
        if (taken && cur != 2'b11) begin
            nxt = cur + 2'd1;
        end else if (!taken && cur != 2'b00) begin
            nxt = cur - 2'd1;
        end
        counter_step = nxt;
    endfunction

endpackage

// ==== gshare/pattern_table.sv ====
`timescale 1ns/100ps

module pattern_table (
    input  logic               clk,
    input  logic               reset,
    input  bp_pkg::pht_index_t read_index,
    input  logic               update,
    input  bp_pkg::pht_index_t update_index,
    input  logic               update_taken,
    output logic               predict_taken
);
    import bp_pkg::*;

    counter_t counters [PHT_ENTRIES];  // one per hashed index

    counter_t cur_count;   // counter at update_index
    counter_t next_count;  // its value after this update
    counter_t read_count;  // counter at read_index

    // read port

    assign read_count    = counters[read_index];
    assign predict_taken = read_count[1];  // upper bit gives direction

    // update port

    assign cur_count  = counters[update_index];
    assign next_count = counter_step(cur_count, update_taken);

    // every counter starts weakly not taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                counters[i] <= COUNTER_INIT;
            end
        end else if (update) begin
            counters[update_index] <= next_count;
        end
    end

endmodule

// ==== rtl/target_buffer.sv ====
`timescale 1ns/100ps

module target_buffer (
    input  logic          clk,
    input  logic          reset,
    input  bp_pkg::addr_t read_pc,
    input  logic          write,
    input  bp_pkg::addr_t write_pc,
    input  bp_pkg::addr_t write_target,
    output logic          hit,
    output bp_pkg::addr_t target
);
    import bp_pkg::*;

    logic [BTB_ENTRIES-1:0] valid;                // cleared on reset
    btb_tag_t               tags    [BTB_ENTRIES];
    addr_t                  targets [BTB_ENTRIES];

    btb_index_t rd_index;
    btb_tag_t   rd_tag;
    btb_index_t wr_index;
    btb_tag_t   wr_tag;

    // split both pcs into index and tag
    assign rd_index = btb_index_of(read_pc);
    assign rd_tag   = btb_tag_of(read_pc);
    assign wr_index = btb_index_of(write_pc);
    assign wr_tag   = btb_tag_of(write_pc);

    // combinational read
    assign hit    = valid[rd_index] && (tags[rd_index] == rd_tag);
    assign target = targets[rd_index];  // only meaningful with hit

    // valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (write) begin
            valid[wr_index] <= 1'b1;
        end
    end

    // tag and target storage overwritten on every install
    always_ff @(posedge clk) begin
        if (write) begin
            tags[wr_index]    <= wr_tag;
            targets[wr_index] <= write_target;
        end
    end

endmodule

// ==== gshare/gshare_predictor.sv ====
`timescale 1ns/100ps

module gshare_predictor (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  logic               history_clear,
    input  bp_pkg::addr_t      fetch_pc,
    input  bp_pkg::resolve_t   resolve,
    output bp_pkg::addr_t      next_pc,
    output bp_pkg::pht_index_t pht_index
);
    import bp_pkg::*;

    hist_t history;        // newest outcome sits in the top bit

    logic  counter_taken;  // upper bit of the indexed counter
    logic  btb_hit;        // valid entry with matching tag
    addr_t btb_target;     // stored target for fetch_pc
    logic  predict_taken;
    addr_t fall_through;

    logic  pht_update;     // conditional branch resolved this cycle
    logic  btb_write;      // install target for resolved pc

    // lookup side

    // gshare hash of history and low pc bits
    assign pht_index = history ^ btb_index_of(fetch_pc);

    assign fall_through = fetch_pc + 32'd4;

    // all three must agree before redirecting fetch
    assign predict_taken = enable && counter_taken && btb_hit;

    assign next_pc = predict_taken ? btb_target : fall_through;

    // resolve side

    assign pht_update = resolve.is_branch;

    // mispredicted branch or any jal/jalr
    assign btb_write = (resolve.is_branch && resolve.mispredict) || resolve.is_jump;

    // global history
    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
        end else if (history_clear) begin
            history <= '0;  // clear wins over a resolve in the same cycle
        end else if (pht_update) begin
            history <= {resolve.taken, history[HIST_BITS-1:1]};
        end
    end

    // direction
    pattern_table u_pht (
        .clk           (clk),
        .reset         (reset),
        .read_index    (pht_index),
        .update        (pht_update),
        .update_index  (resolve.pht_index),  // index the pipeline carried down
        .update_taken  (resolve.taken),
        .predict_taken (counter_taken)
    );

    // targets
    target_buffer u_btb (
        .clk          (clk),
        .reset        (reset),
        .read_pc      (fetch_pc),
        .write        (btb_write),
        .write_pc     (resolve.pc),
        .write_target (resolve.target),
        .hit          (btb_hit),
        .target       (btb_target)
    );

endmodule

// ==== rtl/bp_config.sv ====
`timescale 1ns/100ps

module bp_config (
    input  logic              clk,
    input  logic              reset,
    input  logic              cfg_write,
    input  bp_pkg::cfg_addr_t cfg_addr,
    input  bp_pkg::cfg_data_t cfg_wdata,
    input  bp_pkg::resolve_t  resolve,
    output bp_pkg::cfg_data_t cfg_rdata,
    output logic              enable,
    output logic              history_clear
);
    import bp_pkg::*;

    count_t branch_count;      // resolved conditional branches
    count_t mispredict_count;  // mispredicted conditional branches
    logic   ctrl_write;

    assign ctrl_write = cfg_write && (cfg_addr == REG_CONTROL);

    // bit 1 of the control register is a command and is not stored
    always_ff @(posedge clk) begin
        if (reset) begin
            enable        <= 1'b1;
            history_clear <= 1'b0;
        end else begin
            history_clear <= ctrl_write && cfg_wdata[1];  // one-cycle pulse
            if (ctrl_write) begin
                enable <= cfg_wdata[0];
            end
        end
    end

    // outcome counts saturate at all ones
    always_ff @(posedge clk) begin
        if (reset) begin
            branch_count     <= '0;
            mispredict_count <= '0;
        end else if (resolve.is_branch) begin
            if (branch_count != '1) begin
                branch_count <= branch_count + 16'd1;
            end
            if (resolve.mispredict && mispredict_count != '1) begin
                mispredict_count <= mispredict_count + 16'd1;
            end
        end
    end

    // read decode
    always_comb begin
        case (cfg_addr)
            REG_CONTROL:     cfg_rdata = {15'd0, enable};
            REG_BRANCHES:    cfg_rdata = branch_count;
            REG_MISPREDICTS: cfg_rdata = mispredict_count;
            default:         cfg_rdata = '0;
        endcase
    end

endmodule

// ==== rtl/branch_predictor_top.sv ====
`timescale 1ns/100ps

module branch_predictor_top (
    input  logic               clk,
    input  logic               reset,
    input  bp_pkg::addr_t      fetch_pc,    // pc presented by fetch
    input  bp_pkg::resolve_t   resolve,     // outcome from execute
    input  logic               cfg_write,
    input  bp_pkg::cfg_addr_t  cfg_addr,
    input  bp_pkg::cfg_data_t  cfg_wdata,
    output bp_pkg::addr_t      next_pc,
    output bp_pkg::pht_index_t pht_index,   // carried down the pipeline
    output bp_pkg::cfg_data_t  cfg_rdata
);

    logic enable;         // prediction on or off
    logic history_clear;  // pulse from control write

    // config and status block counting straight from the resolve port
    bp_config u_config (
        .clk           (clk),
        .reset         (reset),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .resolve       (resolve),
        .cfg_rdata     (cfg_rdata),
        .enable        (enable),
        .history_clear (history_clear)
    );

    // direction and target prediction
    gshare_predictor u_predictor (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .history_clear (history_clear),
        .fetch_pc      (fetch_pc),
        .resolve       (resolve),
        .next_pc       (next_pc),
        .pht_index     (pht_index)
    );

endmodule

// ==== tb/bp_assertions.sv ====
`timescale 1ns/100ps

module bp_assertions (
    input logic               clk,
    input logic               reset,
    input bp_pkg::addr_t      fetch_pc,
    input bp_pkg::addr_t      next_pc,
    input bp_pkg::pht_index_t pht_index,
    input bp_pkg::resolve_t   resolve,
    input logic               history_clear
);
    import bp_pkg::*;

    addr_t                  seen_target [BTB_ENTRIES];  // last installed target per index
    logic [BTB_ENTRIES-1:0] seen_valid;
    hist_t                  seen_history;               // rebuilt from resolves and clears

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_valid <= '0;
        end else if (resolve.is_jump || (resolve.is_branch && resolve.mispredict)) begin
            seen_valid[resolve.pc[6:2]]  <= 1'b1;
            seen_target[resolve.pc[6:2]] <= resolve.target;
        end
    end

    // newest taken bit enters at the top
    always_ff @(posedge clk) begin
        if (reset) begin
            seen_history <= '0;
        end else if (history_clear) begin
            seen_history <= '0;
        end else if (resolve.is_branch) begin
            seen_history <= {resolve.taken, seen_history[HIST_BITS-1:1]};
        end
    end

    next_pc_source: assert property (@(posedge clk) disable iff (reset)
        next_pc == fetch_pc + 32'd4 ||
        (seen_valid[fetch_pc[6:2]] && next_pc == seen_target[fetch_pc[6:2]]))
        else $error("next_pc is neither pc+4 nor an installed target");

    fall_through_after_reset: assert property (@(posedge clk)
        ($past(reset) && !reset) |-> next_pc == fetch_pc + 32'd4)
        else $error("next_pc is not pc+4 right after reset");

    index_hash: assert property (@(posedge clk) disable iff (reset)
        pht_index == (seen_history ^ fetch_pc[6:2]))
        else $error("pht_index does not match history xor pc bits");

endmodule

bind branch_predictor_top bp_assertions u_assertions (
    .clk           (clk),
    .reset         (reset),
    .fetch_pc      (fetch_pc),
    .next_pc       (next_pc),
    .pht_index     (pht_index),
    .resolve       (resolve),
    .history_clear (history_clear)
);

// ==== tb/tb_branch_predictor.sv ====
`timescale 1ns/100ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int PIPE_DEPTH = 3;     // cycles between fetch and resolve
    localparam int RUN_CYCLES = 1500;

    typedef struct packed {
        addr_t      pc;
        addr_t      predicted;  // next pc the model expected at fetch
        pht_index_t index;      // index handed out at fetch
        logic [3:0] slot;       // position in the pc pool
    } fetch_rec_t;

    logic       clk;
    logic       reset;
    addr_t      fetch_pc;
    resolve_t   resolve;
    logic       cfg_write;
    cfg_addr_t  cfg_addr;
    cfg_data_t  cfg_wdata;
    addr_t      next_pc;
    pht_index_t pht_index;
    cfg_data_t  cfg_rdata;

    // reference model state
    hist_t       hist;
    counter_t    model_count [PHT_ENTRIES];
    logic        model_valid [BTB_ENTRIES];
    btb_tag_t    model_tag [BTB_ENTRIES];
    addr_t       model_target [BTB_ENTRIES];
    logic        en;
    logic        clear_pulse;   // mirrors the one-cycle clear
    count_t      branch_cnt;
    count_t      mispred_cnt;

    addr_t       pc_pool [12];
    fetch_rec_t  pipe [$];
    logic [31:0] seed;
    int          errors;

    branch_predictor_top uut (
        .clk       (clk),
        .reset     (reset),
        .fetch_pc  (fetch_pc),
        .resolve   (resolve),
        .cfg_write (cfg_write),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .next_pc   (next_pc),
        .pht_index (pht_index),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic addr_t target_of(input addr_t pc);
        return pc + 32'h0000_0400;  // fixed target per pc
    endfunction

    function automatic addr_t model_next_pc(input addr_t pc);
        pht_index_t idx;
        btb_index_t bi;
        bi  = pc[6:2];
        idx = hist ^ pc[6:2];
        if (en && model_count[idx][1] && model_valid[bi] && model_tag[bi] == pc[31:7]) begin
            return model_target[bi];
        end
        return pc + 32'd4;
    endfunction

    // state at the end of the cycle from the inputs applied during it
    task automatic update_model();
        counter_t   c;
        btb_index_t bi;
        if (clear_pulse) begin
            hist = '0;
        end else if (resolve.is_branch) begin
            hist = {resolve.taken, hist[HIST_BITS-1:1]};
        end
        if (resolve.is_branch) begin
            c = model_count[resolve.pht_index];
            if (resolve.taken) begin
                if (c != 2'd3) c = c + 2'd1;
            end else if (c != 2'd0) begin
                c = c - 2'd1;
            end
            model_count[resolve.pht_index] = c;
            if (branch_cnt != 16'hffff) branch_cnt = branch_cnt + 16'd1;
            if (resolve.mispredict && mispred_cnt != 16'hffff) begin
                mispred_cnt = mispred_cnt + 16'd1;
            end
        end
        if ((resolve.is_branch && resolve.mispredict) || resolve.is_jump) begin
            bi               = resolve.pc[6:2];
            model_valid[bi]  = 1'b1;
            model_tag[bi]    = resolve.pc[31:7];
            model_target[bi] = resolve.target;
        end
        clear_pulse = cfg_write && cfg_addr == REG_CONTROL && cfg_wdata[1];
        if (cfg_write && cfg_addr == REG_CONTROL) en = cfg_wdata[0];
    endtask

    task automatic check_outputs();
        cfg_data_t exp_rdata;
        case (cfg_addr)
            REG_CONTROL:     exp_rdata = {15'd0, en};
            REG_BRANCHES:    exp_rdata = branch_cnt;
            REG_MISPREDICTS: exp_rdata = mispred_cnt;
            default:         exp_rdata = '0;
        endcase
        if (next_pc !== model_next_pc(fetch_pc)) begin
            errors++;
            $display("error at %0t ns: next_pc 0x%h, expected 0x%h for pc 0x%h",
                     $time, next_pc, model_next_pc(fetch_pc), fetch_pc);
        end
        if (pht_index !== (hist ^ fetch_pc[6:2])) begin
            errors++;
            $display("error at %0t ns: pht_index %0d, expected %0d for pc 0x%h",
                     $time, pht_index, hist ^ fetch_pc[6:2], fetch_pc);
        end
        if (cfg_rdata !== exp_rdata) begin
            errors++;
            $display("error at %0t ns: register %0d reads 0x%h, expected 0x%h",
                     $time, cfg_addr, cfg_rdata, exp_rdata);
        end
    endtask

    // one cycle of fetch, resolve and config traffic
    task automatic drive_cycle(input logic do_resolve, input logic do_config,
                               input logic force_clear);
        fetch_rec_t  rec;
        fetch_rec_t  old;
        logic [31:0] r;
        int          slot;
        resolve_t    res;
        @(posedge clk);
        #1;
        update_model();
        r             = lcg_next() >> 8;
        slot          = (lcg_next() >> 8) % 32'd12;
        fetch_pc      = pc_pool[slot];
        rec.pc        = pc_pool[slot];
        rec.predicted = model_next_pc(rec.pc);
        rec.index     = hist ^ rec.pc[6:2];
        rec.slot      = 4'(slot);
        pipe.push_back(rec);
        res = '0;
        if (pipe.size() > PIPE_DEPTH) begin
            old = pipe.pop_front();
            if (do_resolve && r[1:0] == 2'd1) begin
                res.is_jump    = 1'b1;
                res.taken      = 1'b1;
                res.mispredict = old.predicted != target_of(old.pc);
            end else if (do_resolve && r[1:0] != 2'd0) begin
                res.is_branch = 1'b1;
                // even slots lean taken, odd slots lean not taken
                res.taken = old.slot[0] ? (r[9:8] == 2'd0) : (r[9:8] != 2'd0);
                if (res.taken) begin
                    res.mispredict = old.predicted != target_of(old.pc);
                end else begin
                    res.mispredict = old.predicted != old.pc + 32'd4;
                end
            end
            res.pc        = old.pc;
            res.target    = target_of(old.pc);
            res.pht_index = old.index;
        end
        resolve   = res;
        cfg_write = 1'b0;
        cfg_wdata = '0;
        cfg_addr  = (r[13:12] == 2'd3) ? REG_CONTROL : r[13:12];  // random read address
        if (force_clear || (do_config && r[20:16] == 5'd0)) begin
            cfg_write = 1'b1;
            cfg_addr  = REG_CONTROL;
            cfg_wdata = force_clear ? 16'h0003 : {14'd0, r[21], r[22] | r[23]};
        end
        #4;
        check_outputs();
    endtask

    task automatic check_register(input cfg_addr_t addr, input count_t expected);
        @(posedge clk);
        #1;
        update_model();
        resolve   = '0;
        cfg_write = 1'b0;
        cfg_addr  = addr;
        #4;
        if (cfg_rdata !== expected) begin
            errors++;
            $display("error at %0t ns: register %0d reads %0d, expected %0d",
                     $time, addr, cfg_rdata, expected);
        end
    endtask

    initial begin
        #200000;
        $display("simulation timed out before the test finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic cleared;
        reset       = 1'b1;
        fetch_pc    = 32'h0000_1000;
        resolve     = '0;
        cfg_write   = 1'b0;
        cfg_addr    = REG_CONTROL;
        cfg_wdata   = '0;
        seed        = 32'd68;
        errors      = 0;
        hist        = '0;
        en          = 1'b1;
        clear_pulse = 1'b0;
        branch_cnt  = '0;
        mispred_cnt = '0;
        for (int i = 0; i < PHT_ENTRIES; i++) model_count[i] = COUNTER_INIT;
        for (int i = 0; i < BTB_ENTRIES; i++) model_valid[i] = 1'b0;
        // pairs at 0/1/11, 2/3, 4/5 and 8/9 share an index with different tags
        pc_pool = '{32'h0000_1000, 32'h0000_1080, 32'h0000_1004, 32'h0000_2004,
                    32'h0000_1010, 32'h0000_3010, 32'h0000_1024, 32'h0000_1048,
                    32'h0000_1068, 32'h0000_4068, 32'h0000_107c, 32'h0000_5000};
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        repeat (20) drive_cycle(1'b0, 1'b0, 1'b0);  // cold tables give pc+4 only
        repeat (RUN_CYCLES) drive_cycle(1'b1, 1'b1, 1'b0);
        repeat (PIPE_DEPTH + 1) drive_cycle(1'b0, 1'b0, 1'b0);
        drive_cycle(1'b0, 1'b0, 1'b1);
        cleared = 1'b0;
        for (int n = 0; n < 8 && !cleared; n++) begin
            drive_cycle(1'b0, 1'b0, 1'b0);
            if (pht_index == fetch_pc[6:2]) cleared = 1'b1;
        end
        if (!cleared) begin
            errors++;
            $display("history clear never brought pht_index back to pc bits 6 to 2");
        end
        check_register(REG_BRANCHES, branch_cnt);
        check_register(REG_MISPREDICTS, mispred_cnt);
        $display("done: %0d errors, %0d branches, %0d mispredicts",
                 errors, branch_cnt, mispred_cnt);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/bp_pkg.sv
gshare/pattern_table.sv
rtl/target_buffer.sv
gshare/gshare_predictor.sv
rtl/bp_config.sv
rtl/branch_predictor_top.sv
tb/bp_assertions.sv
tb/tb_branch_predictor.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_branch_predictor
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

# pass or fail is taken from the log, not from the exit status
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
